// File: filelist.f
+incdir+src
src/sdram_map_pkg.sv
src/rw_bank_slots.sv
src/rom_bank_slots.sv
src/rom_loader.sv
src/sdram_cmd_arbiter.sv
src/sdram_map.sv
testbench/sdram_map_chk.sv
testbench/tb_sdram_map.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SDRAM map testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_sdram_map -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
grep -q "sim passed" sim.log

// File: src/rom_bank_slots.sv
`timescale 1ns/10ps
`include "sdram_map_macros.svh"

module rom_bank_slots import sdram_map_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        gfx_cs,
    input  gfx_slot_t   char_req,
    input  gfx_slot_t   scr_req,
    output logic [31:0] char_data,
    output logic [31:0] scr_data,
    output logic        char_ok,
    output logic        scr_ok,
    output sdram_req_t  req,
    output logic        req_on,
    input  logic        ack,
    input  logic        rdy,
    input  sdram_word_u rd_word
);

    logic [`SDRAM_AW-1:0] slot_addr [2];
    logic [`SDRAM_AW-1:0] tag [2];
    logic [31:0]          data [2];
    logic [1:0]           valid, hit, need;
    logic                 req_rd, wait_rdy, owner;
    logic                 issue, done;
    logic [`SDRAM_AW-1:0] req_addr;

    // Two 16-bit words per fetch
    assign slot_addr[0] = `GFX_START + {8'd0, char_req.addr[12:0], 1'b0};
    assign slot_addr[1] = `GFX_START + `SCR_OFFSET + {4'd0, scr_req.addr, 1'b0};

    always_comb begin
        for (int i = 0; i < 2; i++)
            hit[i] = valid[i] && tag[i] == slot_addr[i];
    end

    assign need = gfx_cs ? ~hit : 2'b00;   // Nothing outside the window

    assign char_ok   = gfx_cs && hit[0];
    assign scr_ok    = gfx_cs && hit[1];
    assign char_data = data[0];
    assign scr_data  = data[1];

    assign issue  = !req_rd && !wait_rdy && |need;
    assign done   = wait_rdy && rdy;
    assign req_on = req_rd;
    assign req    = '{rd: req_rd, wr: 1'b0, addr: req_addr, data: 16'h0000, mask: 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            req_rd   <= 1'b0;
            wait_rdy <= 1'b0;
            valid    <= 2'b00;
        end else begin
            if (req_rd && ack) begin
                req_rd   <= 1'b0;
                wait_rdy <= 1'b1;
            end else if (done) begin
                wait_rdy     <= 1'b0;
                valid[owner] <= 1'b1;
            end else if (issue)
                req_rd <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            owner    <= !need[0];       // Char before scroll
            req_addr <= need[0] ? slot_addr[0] : slot_addr[1];
        end
        if (done) begin
            tag[owner]  <= req_addr;
            data[owner] <= rd_word.word;
        end
    end

endmodule

// File: src/rom_loader.sv
`timescale 1ns/10ps
`include "sdram_map_macros.svh"

module rom_loader import sdram_map_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic        ioctl_wr,
    output sdram_req_t  req,
    output logic        req_on,
    input  logic        ack,
    input  logic        rdy,
    output logic        dwnld_busy,
    output logic        dec_en,
    output logic        dec_type,
    output logic        key_we
);

    logic [24:0]          offs;
    logic [23:0]          word_addr;
    logic                 in_image, in_key, take;
    logic                 req_wr, wait_rdy;
    logic [7:0]           even_byte;
    logic [`SDRAM_AW-1:0] req_addr;
    logic [15:0]          req_data;

    assign offs      = ioctl_addr - 25'(`HEADER_LEN);  // Skip the header
    assign word_addr = offs[24:1];
    assign in_image  = downloading && ioctl_wr && ioctl_addr >= 25'(`HEADER_LEN);
    assign in_key    = word_addr >= `KEY_START;
    // Odd byte completes a word
    assign take      = in_image && !in_key && offs[0] && !req_wr && !wait_rdy;

    assign req_on     = req_wr;
    assign dwnld_busy = downloading | req_wr | wait_rdy;
    assign req        = '{rd: 1'b0, wr: req_wr, addr: req_addr, data: req_data, mask: 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            req_wr   <= 1'b0;
            wait_rdy <= 1'b0;
            key_we   <= 1'b0;
            dec_en   <= 1'b0;
            dec_type <= 1'b0;
        end else begin
            key_we <= in_image && in_key;   // One pulse per key byte
            if (downloading && ioctl_wr && ioctl_addr == 25'(`DEC_REG)) begin
                dec_en   <= |ioctl_data[1:0];
                dec_type <= ioctl_data[1];
            end
            if (req_wr && ack) begin
                req_wr   <= 1'b0;
                wait_rdy <= 1'b1;
            end else if (wait_rdy && rdy)
                wait_rdy <= 1'b0;
            else if (take)
                req_wr <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_image && !offs[0])
            even_byte <= ioctl_data;
        if (take) begin
            req_addr <= word_addr[`SDRAM_AW-1:0];
            req_data <= {even_byte, ioctl_data};  // Even byte goes high
        end
    end

endmodule

// File: src/rw_bank_slots.sv
`timescale 1ns/10ps
`include "sdram_map_macros.svh"

module rw_bank_slots import sdram_map_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  cpu_slot_t   cpu,
    output logic [15:0] ram_data,
    output logic [15:0] rom_data,
    output logic        ram_ok,
    output logic        rom_ok,
    output sdram_req_t  req,
    output logic        req_on,
    input  logic        ack,
    input  logic        rdy,
    input  sdram_word_u rd_word
);

    logic [14:0]          xram_addr;
    logic                 xram_cs;
    logic [`SDRAM_AW-1:0] ram_addr, rom_addr, sel_addr;
    logic [`SDRAM_AW-1:0] tag0, tag1, wr_addr, pend_addr;
    logic                 valid0, valid1, wr_done;
    logic                 hit0, hit1, wr_hit, need0, need1;
    logic                 issue, done;
    logic                 req_rd, req_wr, wait_rdy;
    logic                 owner, pend_wr;    // owner high for the ROM slot
    logic [`SDRAM_AW-1:0] req_addr;
    logic [15:0]          req_data, fill, merged;
    logic [1:0]           req_mask;

    assign xram_cs = cpu.ram_cs | cpu.vram_cs;

    always_comb begin
        xram_addr = {cpu.ram_cs, cpu.addr[13:0]};  // RAM sits above VRAM
        if (cpu.ram_cs)
            xram_addr[13] = 1'b0;                  // Only 16kB of RAM
    end

    assign ram_addr = `RAM_OFFSET + {7'd0, xram_addr};
    assign rom_addr = {5'd0, cpu.addr};
    assign sel_addr = need0 ? ram_addr : rom_addr;

    assign hit0   = valid0 && tag0 == ram_addr;
    assign hit1   = valid1 && tag1 == rom_addr;
    assign wr_hit = wr_done && wr_addr == ram_addr;
    assign need0  = xram_cs && (cpu.rnw ? !hit0 : !wr_hit);
    assign need1  = cpu.rom_cs && !hit1;
    assign ram_ok = xram_cs && (cpu.rnw ? hit0 : wr_hit);
    assign rom_ok = cpu.rom_cs && hit1;

    assign issue  = !req_on && !wait_rdy && (need0 || need1);
    assign done   = wait_rdy && rdy;
    assign req_on = req_rd | req_wr;
    assign req    = '{rd: req_rd, wr: req_wr, addr: req_addr, data: req_data, mask: req_mask};

    // Reads fetch the aligned pair, bit 0 picks the half
    assign fill   = rd_word.half[pend_addr[0]];
    assign merged = {req_mask[1] ? ram_data[15:8] : req_data[15:8],
                     req_mask[0] ? ram_data[7:0]  : req_data[7:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            req_rd   <= 1'b0;
            req_wr   <= 1'b0;
            wait_rdy <= 1'b0;
            valid0   <= 1'b0;
            valid1   <= 1'b0;
            wr_done  <= 1'b0;
        end else begin
            if (!xram_cs || cpu.rnw)
                wr_done <= 1'b0;   // Next write cycle goes out again
            if (req_on && ack) begin
                req_rd   <= 1'b0;
                req_wr   <= 1'b0;
                wait_rdy <= 1'b1;
            end else if (done) begin
                wait_rdy <= 1'b0;
                if (owner)
                    valid1 <= 1'b1;
                else begin
                    if (!pend_wr || req_mask == 2'b00)
                        valid0 <= 1'b1;
                    if (pend_wr)
                        wr_done <= 1'b1;
                end
            end else if (issue) begin
                req_rd <= !(need0 && !cpu.rnw);
                req_wr <= need0 && !cpu.rnw;
                if (need0 && !cpu.rnw)
                    wr_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            owner     <= !need0;           // RAM slot first
            pend_addr <= sel_addr;
            pend_wr   <= need0 && !cpu.rnw;
            req_addr  <= (need0 && !cpu.rnw) ? sel_addr : {sel_addr[`SDRAM_AW-1:1], 1'b0};
            req_data  <= cpu.data;
            req_mask  <= (need0 && !cpu.rnw) ? cpu.dsn : 2'b00;
        end
        if (done) begin
            if (owner) begin
                tag1     <= pend_addr;
                rom_data <= fill;
            end else if (!pend_wr) begin
                tag0     <= pend_addr;
                ram_data <= fill;
            end else begin
                wr_addr <= pend_addr;
                if (valid0 && tag0 == pend_addr)
                    ram_data <= merged;    // Keep masked lanes
                else if (req_mask == 2'b00) begin
                    tag0     <= pend_addr;
                    ram_data <= req_data;
                end
            end
        end
    end

endmodule

// File: src/sdram_cmd_arbiter.sv
`timescale 1ns/10ps

module sdram_cmd_arbiter import sdram_map_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       downloading,
    input  sdram_req_t ld_req,
    input  sdram_req_t rw_req,
    input  sdram_req_t gfx_req,
    input  logic       ld_on,
    input  logic       rw_on,
    input  logic       gfx_on,
    output logic       ld_ack,
    output logic       rw_ack,
    output logic       gfx_ack,
    output logic       ld_rdy,
    output logic       rw_rdy,
    output logic       gfx_rdy,
    output sdram_req_t req,
    input  logic       sdram_ack,
    input  logic       sdram_rdy
);

    logic own_ld, own_rw, own_gfx;
    logic acked;   // Command taken, waiting for rdy
    logic idle;
    logic bank_ok;

    assign idle    = !(own_ld || own_rw || own_gfx);
    assign bank_ok = !downloading;   // Banks wait out the download

    always_ff @(posedge clk) begin
        if (reset) begin
            own_ld  <= 1'b0;
            own_rw  <= 1'b0;
            own_gfx <= 1'b0;
            acked   <= 1'b0;
        end else if (idle) begin
            own_ld  <= ld_on;
            own_rw  <= !ld_on && bank_ok && rw_on;
            own_gfx <= !ld_on && bank_ok && !rw_on && gfx_on;
            acked   <= 1'b0;
        end else begin
            if (sdram_ack)
                acked <= 1'b1;
            if (sdram_rdy) begin
                // Grant ends here
                own_ld  <= 1'b0;
                own_rw  <= 1'b0;
                own_gfx <= 1'b0;
            end
        end
    end

    // Owner's command until the ack, then nothing
    always_comb begin
        req = '0;
        if (!acked) begin
            if (own_ld)
                req = ld_req;
            else if (own_rw)
                req = rw_req;
            else if (own_gfx)
                req = gfx_req;
        end
    end

    assign ld_ack  = sdram_ack && own_ld;
    assign rw_ack  = sdram_ack && own_rw;
    assign gfx_ack = sdram_ack && own_gfx;
    assign ld_rdy  = sdram_rdy && own_ld;
    assign rw_rdy  = sdram_rdy && own_rw;
    assign gfx_rdy = sdram_rdy && own_gfx;

endmodule

// File: src/sdram_map.sv
`timescale 1ns/10ps

module sdram_map import sdram_map_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        lvbl,
    input  logic [8:0]  vrender,
    // Main CPU
    input  cpu_slot_t   cpu,
    output logic [15:0] ram_data,
    output logic [15:0] rom_data,
    output logic        ram_ok,
    output logic        rom_ok,
    // Graphics
    input  logic [12:0] char_addr,
    input  logic [16:0] scr_addr,
    output logic [31:0] char_data,
    output logic [31:0] scr_data,
    output logic        char_ok,
    output logic        scr_ok,
    // ROM download
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic        ioctl_wr,
    output logic        dwnld_busy,
    output logic        dec_en,
    output logic        dec_type,
    output logic        key_we,
    // SDRAM port
    output sdram_req_t  req,
    input  logic        sdram_ack,
    input  logic        sdram_rdy,
    input  logic [31:0] data_read
);

    logic        gfx_cs;
    sdram_word_u rd_word;
    gfx_slot_t   char_req, scr_req;
    sdram_req_t  ld_req, rw_req, gfx_req;
    logic        ld_on, rw_on, gfx_on;
    logic        ld_ack, rw_ack, gfx_ack;
    logic        ld_rdy, rw_rdy, gfx_rdy;

    // Graphics fetch window
    assign gfx_cs = lvbl || vrender == 9'd0 || vrender[8];

    assign rd_word.word  = data_read;
    assign char_req.addr = {4'd0, char_addr};
    assign scr_req.addr  = scr_addr;

    rw_bank_slots rw_bank_i (
        .clk(clk), .reset(reset), .cpu(cpu),
        .ram_data(ram_data), .rom_data(rom_data), .ram_ok(ram_ok), .rom_ok(rom_ok),
        .req(rw_req), .req_on(rw_on), .ack(rw_ack), .rdy(rw_rdy), .rd_word(rd_word)
    );

    rom_bank_slots rom_bank_i (
        .clk(clk), .reset(reset), .gfx_cs(gfx_cs),
        .char_req(char_req), .scr_req(scr_req),
        .char_data(char_data), .scr_data(scr_data), .char_ok(char_ok), .scr_ok(scr_ok),
        .req(gfx_req), .req_on(gfx_on), .ack(gfx_ack), .rdy(gfx_rdy), .rd_word(rd_word)
    );

    rom_loader loader_i (
        .clk(clk), .reset(reset), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr),
        .req(ld_req), .req_on(ld_on), .ack(ld_ack), .rdy(ld_rdy),
        .dwnld_busy(dwnld_busy), .dec_en(dec_en), .dec_type(dec_type), .key_we(key_we)
    );

    sdram_cmd_arbiter arbiter_i (
        .clk(clk), .reset(reset), .downloading(downloading),
        .ld_req(ld_req), .rw_req(rw_req), .gfx_req(gfx_req),
        .ld_on(ld_on), .rw_on(rw_on), .gfx_on(gfx_on),
        .ld_ack(ld_ack), .rw_ack(rw_ack), .gfx_ack(gfx_ack),
        .ld_rdy(ld_rdy), .rw_rdy(rw_rdy), .gfx_rdy(gfx_rdy),
        .req(req), .sdram_ack(sdram_ack), .sdram_rdy(sdram_rdy)
    );

endmodule

// File: src/sdram_map_macros.svh
`ifndef SDRAM_MAP_MACROS_SVH
`define SDRAM_MAP_MACROS_SVH

// SDRAM word address width
`define SDRAM_AW    22

// Word address map
`define RAM_OFFSET  22'h10_0000   // CPU RAM and VRAM, ROM starts at zero
`define GFX_START   22'h08_0000   // Character ROM
`define SCR_OFFSET  22'h00_4000   // Scroll ROM, above the char ROM

// Download words from here on feed the key PROM
`define KEY_START   24'h20_0000

// Download header
`define HEADER_LEN  32
`define DEC_REG     5'h10         // Decoder flags byte

`endif

// File: src/sdram_map_pkg.sv
`include "sdram_map_macros.svh"

package sdram_map_pkg;

    // One SDRAM command, mask is active low per byte lane
    typedef struct packed {
        logic                 rd;
        logic                 wr;
        logic [`SDRAM_AW-1:0] addr;
        logic [15:0]          data;
        logic [1:0]           mask;
    } sdram_req_t;

    // Read word seen as one 32-bit graphics word or as two 16-bit halves
    // half[0] is the word at the even address
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] half;
    } sdram_word_u;

    // Main CPU access bundle
    typedef struct packed {
        logic        ram_cs;
        logic        vram_cs;
        logic        rom_cs;
        logic [16:0] addr;     // Word address
        logic        rnw;
        logic [1:0]  dsn;      // Active low byte strobes
        logic [15:0] data;
    } cpu_slot_t;

    // Graphics fetch, char slot only uses addr[12:0]
    typedef struct packed {
        logic [16:0] addr;
    } gfx_slot_t;

endpackage

// File: testbench/sdram_map_chk.sv
`timescale 1ns/10ps

module sdram_map_chk import sdram_map_pkg::*; (
    input logic       clk,
    input logic       reset,
    input sdram_req_t req,
    input logic       sdram_ack,
    input logic       sdram_rdy,
    input logic       ram_ok,
    input logic       rom_ok,
    input logic       char_ok,
    input logic       scr_ok
);

    logic in_flight;   // Between ack and rdy

    always_ff @(posedge clk) begin
        if (reset)
            in_flight <= 1'b0;
        else if (sdram_ack)
            in_flight <= 1'b1;
        else if (sdram_rdy)
            in_flight <= 1'b0;
    end

    rd_wr_excl: assert property (@(posedge clk) disable iff (reset) !(req.rd && req.wr))
        else $error("rd and wr high together");

    req_hold: assert property (@(posedge clk) disable iff (reset)
        (req.rd || req.wr) && !sdram_ack |=> $stable(req))
        else $error("command changed before sdram_ack");

    one_cmd: assert property (@(posedge clk) disable iff (reset)
        in_flight |-> !(req.rd || req.wr))
        else $error("new command while one is in flight");

    ok_after_reset: assert property (@(posedge clk)
        reset |=> !(ram_ok || rom_ok || char_ok || scr_ok))
        else $error("ok output high right after reset");

endmodule

bind sdram_map sdram_map_chk chk_i (
    .clk(clk), .reset(reset), .req(req), .sdram_ack(sdram_ack), .sdram_rdy(sdram_rdy),
    .ram_ok(ram_ok), .rom_ok(rom_ok), .char_ok(char_ok), .scr_ok(scr_ok)
);

// File: testbench/tb_sdram_map.sv
`timescale 1ns/10ps
`include "sdram_map_macros.svh"

module tb_sdram_map import sdram_map_pkg::*; ();

    typedef enum logic [3:0] {
        OP_HDR, OP_DL, OP_KEY, OP_RAM_WR, OP_VRAM_WR, OP_RAM_RD, OP_VRAM_RD,
        OP_ROM_RD, OP_CHAR, OP_SCR, OP_WIN_OFF
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [24:0] addr;     // Byte address for downloads, word address otherwise
        logic [15:0] data;     // Downloads send data[7:0] first
        logic [1:0]  mask;
        logic [31:0] exp_val;
        logic        cached;   // No SDRAM read allowed
    } test_t;

    localparam int N_TESTS = 21;

    logic        clk, reset, lvbl;
    logic [8:0]  vrender;
    cpu_slot_t   cpu;
    logic [15:0] ram_data, rom_data;
    logic        ram_ok, rom_ok;
    logic [12:0] char_addr;
    logic [16:0] scr_addr;
    logic [31:0] char_data, scr_data;
    logic        char_ok, scr_ok;
    logic        downloading, ioctl_wr;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic        dwnld_busy, dec_en, dec_type, key_we;
    sdram_req_t  req;
    logic        sdram_ack = 1'b0;
    logic        sdram_rdy = 1'b0;
    logic [31:0] data_read = '0;

    test_t       tbl [N_TESTS];
    logic [15:0] mem [int];        // SDRAM model, one entry per word
    integer      seed = 49;
    int          m_state, m_cnt, rd_count, wr_count, key_count;
    int          cycles, limit, errors, passed, dl_bytes;
    sdram_req_t  m_cmd;
    logic [15:0] old;

    sdram_map dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Unwritten words read back as an address pattern
    function automatic logic [15:0] mem_rd(input logic [21:0] a);
        if (mem.exists(int'(a)))
            return mem[int'(a)];
        return 16'(a) ^ 16'(a >> 6) ^ 16'hA55A;
    endfunction

    // CPU RAM map, RAM above VRAM with address bit 13 tied low
    function automatic logic [21:0] ram_map(input logic vram, input logic [16:0] a);
        if (vram)
            return `RAM_OFFSET + 22'(a[13:0]);
        return `RAM_OFFSET + 22'h4000 + 22'(a[12:0]);
    endfunction

    // SDRAM model, ack after two cycles of a held command, rdy 1 to 4 cycles later
    always @(posedge clk) begin
        #1;
        sdram_ack = 1'b0;
        sdram_rdy = 1'b0;
        if (reset) begin
            m_state = 0;
            m_cnt   = 0;
        end else begin
            case (m_state)
                0: if (req.rd || req.wr) begin
                    m_cnt++;
                    if (m_cnt == 2) begin
                        sdram_ack = 1'b1;
                        m_cmd     = req;
                        if (m_cmd.wr) begin
                            old = mem_rd(m_cmd.addr);
                            mem[int'(m_cmd.addr)] = {m_cmd.mask[1] ? old[15:8] : m_cmd.data[15:8],
                                                     m_cmd.mask[0] ? old[7:0] : m_cmd.data[7:0]};
                            wr_count++;
                        end else
                            rd_count++;
                        m_cnt   = $unsigned($random(seed)) % 4;
                        m_state = 1;
                    end
                end else
                    m_cnt = 0;
                default: if (m_cnt == 0) begin
                    sdram_rdy = 1'b1;
                    data_read = {mem_rd(m_cmd.addr + 1), mem_rd(m_cmd.addr)};
                    m_state   = 0;
                end else
                    m_cnt--;
            endcase
        end
    end

    always @(negedge clk)
        if (key_we)
            key_count++;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] want);
        $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, want);
        errors++;
    endtask

    task automatic send_byte(input logic [24:0] a, input logic [7:0] d);
        step();
        downloading = 1'b1;
        ioctl_addr  = a;
        ioctl_data  = d;
        ioctl_wr    = 1'b1;
        step();
        ioctl_wr = 1'b0;
    endtask

    // Drop downloading and wait out the pending word
    task automatic end_download();
        step();
        downloading = 1'b0;
        @(negedge clk);
        while (dwnld_busy)
            @(negedge clk);
    endtask

    task automatic run_test(input int i);
        test_t       t;
        int          rd_before, wr_before, key_before, err_before, quiet_bad;
        logic        vram;
        logic [21:0] wa;
        t          = tbl[i];
        rd_before  = rd_count;
        wr_before  = wr_count;
        key_before = key_count;
        err_before = errors;
        quiet_bad  = 0;
        vram       = t.op inside {OP_VRAM_WR, OP_VRAM_RD};
        case (t.op)
            OP_HDR: begin
                for (int b = 0; b < `HEADER_LEN; b++)
                    send_byte(25'(b), b == `DEC_REG ? t.data[7:0] : 8'(b));
                end_download();
                if ({dec_en, dec_type} !== t.exp_val[1:0])
                    mismatch("dec_en/dec_type", {dec_en, dec_type}, t.exp_val[1:0]);
            end
            OP_DL, OP_KEY: begin
                send_byte(t.addr, t.data[7:0]);
                send_byte(t.addr + 25'd1, t.data[15:8]);
                end_download();
                wa = 22'((t.addr - `HEADER_LEN) >> 1);   // Swapped word lands here
                if (t.op == OP_DL && mem_rd(wa) !== t.exp_val[15:0])
                    mismatch("SDRAM word", mem_rd(wa), t.exp_val);
                if (t.op == OP_KEY && key_count - key_before != t.exp_val)
                    mismatch("key_we pulse count", key_count - key_before, t.exp_val);
                if (t.op == OP_KEY && wr_count != wr_before) begin
                    $display("Test %0d: key PROM bytes were written to the SDRAM", i);
                    errors++;
                end
            end
            OP_RAM_WR, OP_VRAM_WR, OP_RAM_RD, OP_VRAM_RD: begin
                wa = ram_map(vram, t.addr[16:0]);
                step();
                cpu.ram_cs  = !vram;
                cpu.vram_cs = vram;
                cpu.addr    = t.addr[16:0];
                cpu.rnw     = t.op inside {OP_RAM_RD, OP_VRAM_RD};
                cpu.dsn     = t.mask;
                cpu.data    = t.data;
                @(negedge clk);
                while (!ram_ok)
                    @(negedge clk);
                if (cpu.rnw && ram_data !== t.exp_val[15:0])
                    mismatch("ram_data", ram_data, t.exp_val);
                if (mem_rd(wa) !== t.exp_val[15:0])
                    mismatch("SDRAM word in RAM region", mem_rd(wa), t.exp_val);
            end
            OP_ROM_RD: begin
                step();
                cpu.rom_cs = 1'b1;
                cpu.addr   = t.addr[16:0];
                cpu.rnw    = 1'b1;
                @(negedge clk);
                while (!rom_ok)
                    @(negedge clk);
                if (rom_data !== t.exp_val[15:0])
                    mismatch("rom_data", rom_data, t.exp_val);
            end
            default: begin
                step();
                if (t.op == OP_SCR)
                    scr_addr = t.addr[16:0];
                else
                    char_addr = t.addr[12:0];
                if (t.op == OP_WIN_OFF) begin
                    vrender = t.data[8:0];
                    repeat (20) begin
                        @(negedge clk);
                        if (char_ok || scr_ok || req.rd)
                            quiet_bad++;
                    end
                    if (quiet_bad != 0) begin
                        $display("Test %0d: graphics activity with the window closed", i);
                        errors++;
                    end
                    step();
                end
                lvbl = 1'b1;
                @(negedge clk);
                while (t.op == OP_SCR ? !scr_ok : !char_ok)
                    @(negedge clk);
                if (t.op == OP_SCR && scr_data !== t.exp_val)
                    mismatch("scr_data", scr_data, t.exp_val);
                if (t.op != OP_SCR && char_data !== t.exp_val)
                    mismatch("char_data", char_data, t.exp_val);
            end
        endcase
        if (t.cached && rd_count != rd_before) begin
            $display("Test %0d: repeated read went out to the SDRAM", i);
            errors++;
        end
        step();
        cpu     = '0;
        lvbl    = 1'b0;
        vrender = 9'd50;
        if (errors == err_before)
            passed++;
        $display("Test %0d %s %s", i, t.op.name(), errors == err_before ? "ok" : "FAILED");
    endtask

    task automatic load_table();
        tbl[0]  = '{OP_HDR,     25'h0,      16'h0003, 2'b00, 32'h3,        1'b0};
        tbl[1]  = '{OP_DL,      25'h40,     16'h3412, 2'b00, 32'h1234,     1'b0};
        tbl[2]  = '{OP_DL,      25'h42,     16'h7856, 2'b00, 32'h5678,     1'b0};
        tbl[3]  = '{OP_DL,      25'h100034, 16'hBBAA, 2'b00, 32'hAABB,     1'b0};
        tbl[4]  = '{OP_DL,      25'h100036, 16'hDDCC, 2'b00, 32'hCCDD,     1'b0};
        tbl[5]  = '{OP_DL,      25'h10802C, 16'h2211, 2'b00, 32'h1122,     1'b0};
        tbl[6]  = '{OP_DL,      25'h10802E, 16'h4433, 2'b00, 32'h3344,     1'b0};
        tbl[7]  = '{OP_DL,      25'h1000A0, 16'h6655, 2'b00, 32'h5566,     1'b0};
        tbl[8]  = '{OP_DL,      25'h1000A2, 16'h8877, 2'b00, 32'h7788,     1'b0};
        tbl[9]  = '{OP_KEY,     25'h400020, 16'hF0E1, 2'b00, 32'd2,        1'b0};
        tbl[10] = '{OP_ROM_RD,  25'h10,     16'h0,    2'b00, 32'h1234,     1'b0};
        tbl[11] = '{OP_ROM_RD,  25'h11,     16'h0,    2'b00, 32'h5678,     1'b0};
        tbl[12] = '{OP_ROM_RD,  25'h11,     16'h0,    2'b00, 32'h5678,     1'b1};
        tbl[13] = '{OP_CHAR,    25'h5,      16'h0,    2'b00, 32'hCCDDAABB, 1'b0};
        tbl[14] = '{OP_SCR,     25'h3,      16'h0,    2'b00, 32'h33441122, 1'b0};
        tbl[15] = '{OP_RAM_WR,  25'h100,    16'h3CC3, 2'b10, 32'hA5C3,     1'b0};
        tbl[16] = '{OP_RAM_RD,  25'h100,    16'h0,    2'b00, 32'hA5C3,     1'b0};
        tbl[17] = '{OP_VRAM_WR, 25'h123,    16'hBEEF, 2'b00, 32'hBEEF,     1'b0};
        tbl[18] = '{OP_VRAM_WR, 25'h123,    16'h55AA, 2'b01, 32'h55EF,     1'b0};
        tbl[19] = '{OP_VRAM_RD, 25'h123,    16'h0,    2'b00, 32'h55EF,     1'b1};
        tbl[20] = '{OP_WIN_OFF, 25'h20,     16'd100,  2'b00, 32'h77885566, 1'b0};
    endtask

    initial begin
        reset       = 1'b1;
        lvbl        = 1'b0;
        vrender     = 9'd50;    // Window closed outside the graphics tests
        cpu         = '0;
        char_addr   = '0;
        scr_addr    = '0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        load_table();
        dl_bytes = `HEADER_LEN;
        foreach (tbl[k])
            if (tbl[k].op inside {OP_DL, OP_KEY})
                dl_bytes += 2;
        limit = N_TESTS * 40 + dl_bytes * 12;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < N_TESTS; i++)
            run_test(i);
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 N_TESTS, passed, N_TESTS - passed, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule
